/* hdl/interp_pkg.sv */
package interp_pkg;

   // Sample counts
   localparam int N_IN  = 6;                  // Input points per set.
   localparam int N_MID = 2 * N_IN - 1;       // Points after stage one.
   localparam int N_OUT = 2 * N_MID - 1;      // Points after stage two.

   // Word widths
   localparam int SAMPLE_W = 8;               // Input sample width.
   localparam int WORK_W   = 9;               // Stage arithmetic width, results wrap here.
   localparam int OUT_W    = 16;              // Output bank width.

   // Pipeline timing, in rising edges counted from E0.
   localparam int STAGE_LAT  = 3;             // Load edge to valid stage result.
   localparam int LOAD2_EDGE = 1 + STAGE_LAT;          // Stage two capture edge.
   localparam int BANK_EDGE  = LOAD2_EDGE + STAGE_LAT; // Bank update and ack edge.
   localparam int CNT_W      = $clog2(BANK_EDGE + 1);

   // Controller state codes
   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_RUN  = 2'd1;
   localparam logic [1:0] ST_HOLD = 2'd2;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [WORK_W-1:0]   work_t;
   typedef logic signed [OUT_W-1:0]    out_t;

endpackage

/* hdl/interp_ctrl.sv */
`timescale 1ns/1ns

module interp_ctrl
   import interp_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic req,
   output logic ack,
   output logic load1,
   output logic load2,
   output logic bank_load
);

   logic [1:0]       state;
   logic [CNT_W-1:0] cnt;    // Holds m just before edge Em of a run.
   logic             armed;  // Req seen low since the last handshake.

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= ST_IDLE;
         cnt       <= '0;
         armed     <= 1'b1;
         ack       <= 1'b0;
         load1     <= 1'b0;
         load2     <= 1'b0;
         bank_load <= 1'b0;
      end
      else
      begin
         // Strobes last a single cycle.
         load1     <= 1'b0;
         load2     <= 1'b0;
         bank_load <= 1'b0;

         case (state)
            ST_IDLE:
            begin
               if (!req)
               begin
                  armed <= 1'b1;
               end
               else if (armed)
               begin
                  // This is E0; stage one captures din at E1.
                  armed <= 1'b0;
                  load1 <= 1'b1;
                  cnt   <= CNT_W'(1);
                  state <= ST_RUN;
               end
            end

            ST_RUN:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(LOAD2_EDGE - 1))
               begin
                  load2 <= 1'b1;                 // Stage one result is valid.
               end
               if (cnt == CNT_W'(BANK_EDGE - 1))
               begin
                  bank_load <= 1'b1;             // Stage two result is valid.
               end
               if (cnt == CNT_W'(BANK_EDGE))
               begin
                  ack   <= 1'b1;                 // Bank updates on this same edge.
                  state <= ST_HOLD;
               end
            end

            ST_HOLD:
            begin
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= ST_IDLE;
               end
            end

            default:
            begin
               ack   <= 1'b0;
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/interp_stage.sv */
`timescale 1ns/1ns

module interp_stage
   import interp_pkg::*;
#(
   parameter int N_PTS = N_IN,
   parameter int IN_W  = SAMPLE_W
)
(
   input  logic                   clk,
   input  logic                   load,
   input  logic signed [IN_W-1:0] pts_in  [N_PTS],
   output work_t                  pts_out [2*N_PTS-1]
);

   // Input points at working width.
   work_t pts_r [N_PTS];

   // Level one, one entry per gap between neighbouring points.
   work_t even_q [N_PTS];     // Original points, delayed to line up.
   work_t p38_q  [N_PTS-1];   // Three-eighths term.
   work_t p34_q  [N_PTS-1];   // Three-quarters term.
   work_t m18_q  [N_PTS-1];   // One-eighth term, subtracted.

   // Shift-and-add weights of the quadratic midpoint estimate.
   function automatic work_t three_eighths(input work_t p);
      return (p >>> 2) + (p >>> 3);
   endfunction

   function automatic work_t three_quarters(input work_t p);
      return (p >>> 1) + (p >>> 2);
   endfunction

   function automatic work_t one_eighth(input work_t p);
      return p >>> 3;
   endfunction

   // Input register.
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         for (int k = 0; k < N_PTS; k++)
         begin
            pts_r[k] <= pts_in[k];    // Sign-extends to WORK_W.
         end
      end
   end

   // First arithmetic level.
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < N_PTS; k++)
      begin
         even_q[k] <= pts_r[k];
      end

      // Gap g sits between points g and g+1 and looks ahead to g+2.
      for (int g = 0; g < N_PTS - 2; g++)
      begin
         p38_q[g] <= three_eighths(pts_r[g]);
         p34_q[g] <= three_quarters(pts_r[g+1]);
         m18_q[g] <= one_eighth(pts_r[g+2]);
      end

      // No point to the right of the last gap, so look back instead.
      p38_q[N_PTS-2] <= three_eighths(pts_r[N_PTS-1]);
      p34_q[N_PTS-2] <= three_quarters(pts_r[N_PTS-2]);
      m18_q[N_PTS-2] <= one_eighth(pts_r[N_PTS-3]);
   end

   // Second arithmetic level, interleaving kept and new points.
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < N_PTS; k++)
      begin
         pts_out[2*k] <= even_q[k];
      end

      for (int g = 0; g < N_PTS - 1; g++)
      begin
         pts_out[2*g+1] <= p38_q[g] + p34_q[g] - m18_q[g];   // Wraps to WORK_W.
      end
   end

endmodule

/* hdl/result_bank.sv */
`timescale 1ns/1ns

module result_bank
   import interp_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  load,
   input  work_t pts_in [N_OUT],
   output out_t  dout   [N_OUT]
);

   // Output bank, held between handshakes.
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int k = 0; k < N_OUT; k++)
         begin
            dout[k] <= '0;
         end
      end
      else if (load)
      begin
         for (int k = 0; k < N_OUT; k++)
         begin
            dout[k] <= pts_in[k];     // Sign-extends to OUT_W.
         end
      end
   end

endmodule

/* hdl/quad_interp_top.sv */
`timescale 1ns/1ns

module quad_interp_top
   import interp_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  sample_t din  [N_IN],
   input  logic    req,
   output logic    ack,
   output out_t    dout [N_OUT]
);

   logic  load1;
   logic  load2;
   logic  bank_load;

   work_t mid_pts [N_MID];    // Stage one result.
   work_t fin_pts [N_OUT];    // Stage two result.

   // Handshake and load timing.
   interp_ctrl ctrl_i
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .ack       (ack),
      .load1     (load1),
      .load2     (load2),
      .bank_load (bank_load)
   );

   // 6 points to 11.
   interp_stage
   #(
      .N_PTS (N_IN),
      .IN_W  (SAMPLE_W)
   )
   stage1_i
   (
      .clk     (clk),
      .load    (load1),
      .pts_in  (din),
      .pts_out (mid_pts)
   );

   // 11 points to 21.
   interp_stage
   #(
      .N_PTS (N_MID),
      .IN_W  (WORK_W)
   )
   stage2_i
   (
      .clk     (clk),
      .load    (load2),
      .pts_in  (mid_pts),
      .pts_out (fin_pts)
   );

   result_bank bank_i
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .load   (bank_load),
      .pts_in (fin_pts),
      .dout   (dout)
   );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 2;    // 4 ns clock period.
   localparam int RST_CYCLES  = 16;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial
   begin
      rst_n <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* sim/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

int unsigned lcg_state;              // Random generator state.
sample_t     set_pts  [N_IN];        // Input set of the current transaction.
int          work_pts [N_OUT];       // Points while the stage rule is applied.
out_t        exp_dout [N_OUT];       // Expected output bank.

function automatic int unsigned next_random();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic sample_t random_sample();
   return sample_t'(next_random() >> 16);
endfunction

// Keeps the low 9 bits as a signed value.
function automatic int wrap_work(input int v);
   int r;
   r = v & 511;
   if (r > 255)
   begin
      r = r - 512;
   end
   return r;
endfunction

// Weights 3/8, 3/4 and -1/8 on three neighbouring points.
function automatic int midpoint(input int a, input int b, input int c);
   int t38;
   int t34;
   int t18;
   t38 = (a >>> 2) + (a >>> 3);
   t34 = (b >>> 1) + (b >>> 2);
   t18 = c >>> 3;
   return wrap_work(t38 + t34 - t18);
endfunction

// Doubles the density of the first n entries of work_pts.
function automatic void double_points(input int n);
   int src [N_OUT];
   src = work_pts;
   for (int k = 0; k < n; k++)
   begin
      work_pts[2*k] = src[k];
   end
   for (int g = 0; g < n - 2; g++)
   begin
      work_pts[2*g+1] = midpoint(src[g], src[g+1], src[g+2]);
   end
   work_pts[2*n-3] = midpoint(src[n-1], src[n-2], src[n-3]);   // Last gap looks back.
endfunction

function automatic void compute_expected();
   for (int k = 0; k < N_IN; k++)
   begin
      work_pts[k] = int'(set_pts[k]);
   end
   double_points(N_IN);
   double_points(N_MID);
   for (int k = 0; k < N_OUT; k++)
   begin
      exp_dout[k] = out_t'(work_pts[k]);
   end
endfunction

`endif

/* sim/tb_quad_interp.sv */
`timescale 1ns/1ns

module tb_quad_interp
   import interp_pkg::*;
();

   localparam int ACK_EDGES  = 7;     // E0 to ack rise.
   localparam int WAIT_LIMIT = 64;    // Edges before a wait gives up.
   localparam int N_RANDOM   = 56;

   logic    clk;
   logic    rst_n;
   sample_t din  [N_IN];
   logic    req;
   logic    ack;
   out_t    dout [N_OUT];

   `include "tb_ref_model.svh"

   tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

   quad_interp_top dut_i
   (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (din),
      .req   (req),
      .ack   (ack),
      .dout  (dout)
   );

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      stop_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
   endtask

   task automatic check_bank(input string where);
      for (int k = 0; k < N_OUT; k++)
      begin
         assert (dout[k] == exp_dout[k])
            else report_mismatch($sformatf("%s, dout[%0d] is %0d, expected %0d",
                                           where, k, dout[k], exp_dout[k]));
      end
   endtask

   function automatic sample_t random_point();
      case ((next_random() >> 24) % 8)
         0: return 8'sh80;
         1: return 8'sh7f;
         default: return random_sample();
      endcase
   endfunction

   function automatic void fill_directed_set(input int which);
      for (int k = 0; k < N_IN; k++)
      begin
         case (which)
            0: set_pts[k] = 8'sh7f;
            1: set_pts[k] = 8'sh80;
            2: set_pts[k] = (k % 2 == 0) ? 8'sh80 : 8'sh7f;
            default: set_pts[k] = (k % 2 == 0) ? 8'sh7f : 8'sh80;
         endcase
      end
   endfunction

   function automatic void fill_random_set();
      for (int k = 0; k < N_IN; k++)
      begin
         set_pts[k] = random_point();
      end
   endfunction

   task automatic scramble_din();
      for (int k = 0; k < N_IN; k++)
      begin
         din[k] <= random_sample();
      end
   endtask

   task automatic check_reset();
      int waited;
      waited = 0;
      @(posedge clk);
      @(negedge clk);
      while (rst_n !== 1'b1)
      begin
         assert (ack == 1'b0) else report_mismatch("ack high during reset");
         check_bank("during reset");
         waited++;
         if (waited > WAIT_LIMIT)
         begin
            stop_run("Timed out waiting for reset to be released.");
         end
         @(negedge clk);
      end
      repeat (2)
      begin
         assert (ack == 1'b0) else report_mismatch("ack high after reset");
         check_bank("after reset");
         @(negedge clk);
      end
   endtask

   task automatic run_transaction();
      int edges;
      int hold_cycles;
      int gap;

      compute_expected();
      @(posedge clk);
      for (int k = 0; k < N_IN; k++)
      begin
         din[k] <= set_pts[k];
      end
      req <= 1'b1;

      edges = 0;
      do
      begin
         if (edges == WAIT_LIMIT)
         begin
            stop_run("Timed out waiting for ack to rise.");
         end
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      while (ack !== 1'b1);

      // The first edge after the drive edge is E0.
      assert (edges - 1 == ACK_EDGES)
         else report_mismatch($sformatf("ack rose %0d edges after E0, expected %0d",
                                        edges - 1, ACK_EDGES));
      check_bank("at ack");
      for (int k = 0; k < N_IN; k++)
      begin
         assert (dout[4*k] == out_t'(set_pts[k]))
            else report_mismatch($sformatf("dout[%0d] is %0d, expected din[%0d] = %0d",
                                           4 * k, dout[4*k], k, set_pts[k]));
      end

      hold_cycles = 1 + int'((next_random() >> 20) % 4);
      repeat (hold_cycles)
      begin
         @(posedge clk);
         scramble_din();
         @(negedge clk);
         assert (ack == 1'b1) else report_mismatch("ack fell while req was high");
         check_bank("while ack high");
      end

      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      assert (ack == 1'b1) else report_mismatch("ack fell on the edge that dropped req");
      edges = 0;
      do
      begin
         if (edges == WAIT_LIMIT)
         begin
            stop_run("Timed out waiting for ack to fall.");
         end
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      while (ack !== 1'b0);
      assert (edges == 1)
         else report_mismatch($sformatf("ack fell %0d edges after req was sampled low",
                                        edges));

      gap = 1 + int'((next_random() >> 20) % 3);
      repeat (gap)
      begin
         @(posedge clk);
         scramble_din();
         @(negedge clk);
         assert (ack == 1'b0) else report_mismatch("ack high while idle");
         check_bank("while idle");
      end
   endtask

   initial
   begin
      req       <= 1'b0;
      lcg_state = 32'hbf64;
      for (int k = 0; k < N_IN; k++)
      begin
         din[k] <= '0;
      end
      for (int k = 0; k < N_OUT; k++)
      begin
         exp_dout[k] = '0;    // Bank clears on reset.
      end

      check_reset();
      for (int d = 0; d < 4; d++)
      begin
         fill_directed_set(d);
         run_transaction();
      end
      for (int r = 0; r < N_RANDOM; r++)
      begin
         fill_random_set();
         run_transaction();
      end

      $display("all tests passed");
      $finish;
   end

endmodule

/* src.f */
+incdir+sim
hdl/interp_pkg.sv
hdl/interp_ctrl.sv
hdl/interp_stage.sv
hdl/result_bank.sv
hdl/quad_interp_top.sv
sim/tb_clock_gen.sv
sim/tb_quad_interp.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a nonzero exit status means failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f src.f --top-module tb_quad_interp -o tb_quad_interp \
   && ./obj_dir/tb_quad_interp \
   || { echo "Simulation did not pass."; exit 1; }
